// ==== build.f ====
verilog/ahb_pkg.sv
verilog/ahblite_slave.sv
verilog/periph_ram.sv
verilog/ahb_subsystem.sv
test/ahb_subsystem_asserts.sv
test/tb_ahb_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and decide on the log contents

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_ahb_subsystem \
    -f build.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_ahb_subsystem > "$LOG" 2>&1 \
    || echo "Simulation exited with an error status"

cat "$LOG"

grep -qx "Result: PASSED" "$LOG" && exit 0 || exit 1

// ==== test/tb_ahb_subsystem.sv ====
`default_nettype none

module tb_ahb_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import ahb_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_ZERO       = 16;
    localparam int N_WORD       = 32;
    localparam int N_NARROW     = 32;
    localparam int N_ERR        = 10;
    localparam int N_BURST      = 6;                   // Four beats each way
    localparam int N_IDLE       = 20;
    localparam int N_XFERS      = N_ZERO + 2 * N_WORD + 3 * N_NARROW + 2 * N_ERR
                                  + 8 * N_BURST + 2 * N_IDLE;
    localparam int TIMEOUT_CYCLES = N_XFERS * (RAM_WAIT + 3) + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        ahb_req_t req;
        hdata_t   wdata;
    } xfer_t;

    logic      hclk;
    logic      hresetn;
    ahb_req_t  ahb_req;
    hdata_t    hwdata;
    ahb_resp_t ahb_resp;

    hdata_t      model [RAM_WORDS];
    xfer_t       xq [$];
    logic [31:0] lfsr_state = 32'd87350;
    int          n_checks = 0;
    int          n_errors = 0;

    ahb_subsystem i_ahb_subsystem (
         .hclk     (hclk)
        ,.hresetn  (hresetn)
        ,.ahb_req  (ahb_req)
        ,.hwdata   (hwdata)
        ,.ahb_resp (ahb_resp)
    );

    initial begin
        hclk = 1'b0;
        forever #2 hclk = ~hclk;
    end

    function automatic logic next_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Aligned to the access size with word alignment above a word
    function automatic haddr_t rand_addr(input hsize_t size);
        haddr_t a;
        a = rand_bits(32);
        if (size == HSIZE_HALF) begin
            a[0] = 1'b0;
        end else if (size != HSIZE_BYTE) begin
            a[1:0] = 2'b00;
        end
        return a;
    endfunction

    function automatic ahb_req_t idle_req();
        ahb_req_t r;
        r        = '0;
        r.htrans = HTRANS_IDLE;
        return r;
    endfunction

    function automatic xfer_t make_xfer(input logic hsel, input logic [1:0] htrans,
                                        input logic hwrite, input hsize_t hsize,
                                        input haddr_t haddr, input hdata_t wdata);
        xfer_t x;
        x.req.hsel   = hsel;
        x.req.htrans = htrans;
        x.req.hwrite = hwrite;
        x.req.hsize  = hsize;
        x.req.haddr  = haddr;
        x.wdata      = wdata;
        return x;
    endfunction

    function automatic xfer_t read_xfer(input haddr_t haddr);
        return make_xfer(1'b1, HTRANS_NONSEQ, 1'b0, HSIZE_WORD, haddr, '0);
    endfunction

    function automatic logic is_transfer(input logic [1:0] htrans);
        return (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
    endfunction

    function automatic strb_t lane_mask(input hsize_t size, input logic [1:0] low);
        strb_t m;
        m = '0;
        case (size)
            HSIZE_BYTE: m[low] = 1'b1;
            HSIZE_HALF: m = low[1] ? 4'b1100 : 4'b0011;
            default:    m = 4'b1111;
        endcase
        return m;
    endfunction

    function automatic void model_write(input haddr_t addr, input hsize_t size,
                                        input hdata_t data);
        ram_idx_t idx;
        strb_t    m;
        idx = addr[9:2];                                   // Upper bits wrap
        m   = lane_mask(size, addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("CHECK FAILED %s: actual 0x%08h expected 0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Pipelined master where the next address phase overlaps the last data-phase cycle
    task automatic run_bus();
        xfer_t  ap;
        xfer_t  dp;
        logic   ap_v;
        logic   dp_v;
        logic   dp_err;
        logic   rdy;
        logic   resp;
        logic   pacc;
        hdata_t rdata;
        int     waits;
        ap    = '0;
        dp    = '0;
        ap_v  = 1'b0;
        dp_v  = 1'b0;
        waits = 0;
        while (xq.size() > 0 || ap_v || dp_v) begin
            @(negedge hclk);
            rdy    = ahb_resp.hreadyout;
            resp   = ahb_resp.hresp;
            rdata  = ahb_resp.hrdata;
            pacc   = i_ahb_subsystem.mem_req.pread || i_ahb_subsystem.mem_req.pwrite;
            dp_err = (dp.req.hsize > HSIZE_WORD);
            if (dp_v) begin
                check("hresp", 32'(resp), 32'(dp_err));
                check("ram_access", 32'(pacc), 32'(!dp_err));
                if (!rdy) begin
                    waits++;
                end else begin
                    check("wait_cycles", waits, dp_err ? 1 : RAM_WAIT);
                    if (!dp_err && dp.req.hwrite) begin
                        model_write(dp.req.haddr, dp.req.hsize, dp.wdata);
                    end else if (!dp_err) begin
                        check("hrdata", rdata, model[dp.req.haddr[9:2]]);
                    end
                end
            end else begin
                check("hreadyout", 32'(rdy), 32'd1);      // No data phase in flight
                check("hresp", 32'(resp), 32'd0);
                check("ram_access", 32'(pacc), 32'd0);
            end
            @(posedge hclk);
            if (rdy) begin
                dp_v  = ap_v && ap.req.hsel && is_transfer(ap.req.htrans);
                dp    = ap;
                waits = 0;
                if (xq.size() > 0) begin
                    ap   = xq.pop_front();
                    ap_v = 1'b1;
                end else begin
                    ap   = '0;
                    ap_v = 1'b0;
                end
                ahb_req <= ap.req;
                hwdata  <= dp.wdata;
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge hclk);
        check("hreadyout", 32'(ahb_resp.hreadyout), 32'd1);
        check("hresp", 32'(ahb_resp.hresp), 32'd0);
        for (int i = 0; i < N_ZERO; i++) begin
            xq.push_back(read_xfer(rand_addr(HSIZE_WORD)));
        end
        run_bus();
    endtask

    task automatic test_word_alias();
        haddr_t      addrs [N_WORD];
        logic [31:0] r;
        for (int i = 0; i < N_WORD; i++) begin
            addrs[i] = rand_addr(HSIZE_WORD);
            xq.push_back(make_xfer(1'b1, HTRANS_NONSEQ, 1'b1, HSIZE_WORD, addrs[i],
                                   rand_bits(32)));
        end
        for (int i = 0; i < N_WORD; i++) begin
            r = rand_bits(22);                             // New upper bits with the same index
            xq.push_back(read_xfer({r[21:0], addrs[i][9:0]}));
        end
        run_bus();
    endtask

    task automatic test_narrow_writes();
        haddr_t addrs [N_NARROW];
        hsize_t size;
        for (int i = 0; i < N_NARROW; i++) begin
            size     = next_bit() ? HSIZE_HALF : HSIZE_BYTE;
            addrs[i] = rand_addr(size);
            xq.push_back(make_xfer(1'b1, HTRANS_NONSEQ, 1'b1, HSIZE_WORD,
                                   {addrs[i][31:2], 2'b00}, rand_bits(32)));
            xq.push_back(make_xfer(1'b1, HTRANS_NONSEQ, 1'b1, size, addrs[i],
                                   rand_bits(32)));
        end
        for (int i = 0; i < N_NARROW; i++) begin
            xq.push_back(read_xfer({addrs[i][31:2], 2'b00}));
        end
        run_bus();
    endtask

    task automatic test_error_response();
        haddr_t a;
        hsize_t size;
        for (int i = 0; i < N_ERR; i++) begin
            a    = rand_addr(HSIZE_WORD);
            size = hsize_t'(3 + (i % 5));                  // Sweeps sizes 3 to 7
            xq.push_back(make_xfer(1'b1, HTRANS_NONSEQ, (i % 3) != 0, size, a,
                                   rand_bits(32)));
            xq.push_back(read_xfer(a));
        end
        run_bus();
    endtask

    task automatic test_pipelined_bursts();
        haddr_t base;
        for (int k = 0; k < N_BURST; k++) begin
            base = rand_addr(HSIZE_WORD);
            for (int j = 0; j < 4; j++) begin
                xq.push_back(make_xfer(1'b1, (j == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b1,
                                       HSIZE_WORD, base + haddr_t'(4 * j), rand_bits(32)));
            end
            for (int j = 0; j < 4; j++) begin
                xq.push_back(make_xfer(1'b1, (j == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b0,
                                       HSIZE_WORD, base + haddr_t'(4 * j), '0));
            end
        end
        run_bus();
    endtask

    task automatic test_no_transfer();
        haddr_t     a;
        logic [1:0] kind;
        for (int i = 0; i < N_IDLE; i++) begin
            a    = rand_addr(HSIZE_WORD);
            kind = {next_bit(), next_bit()};
            case (kind)
                2'd0:    xq.push_back(make_xfer(1'b0, HTRANS_NONSEQ, 1'b1, HSIZE_WORD, a,
                                                rand_bits(32)));
                2'd1:    xq.push_back(make_xfer(1'b1, HTRANS_IDLE, 1'b1, HSIZE_WORD, a,
                                                rand_bits(32)));
                2'd2:    xq.push_back(make_xfer(1'b1, HTRANS_BUSY, 1'b1, HSIZE_WORD, a,
                                                rand_bits(32)));
                default: xq.push_back(make_xfer(1'b0, HTRANS_SEQ, 1'b1, HSIZE_WORD, a,
                                                rand_bits(32)));
            endcase
            xq.push_back(read_xfer(a));
        end
        run_bus();
    endtask

    initial begin : main
        hresetn = 1'b0;
        ahb_req = idle_req();
        hwdata  = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge hclk);
        hresetn <= 1'b1;
        test_reset_state();
        test_word_alias();
        test_narrow_writes();
        test_error_response();
        test_pipelined_bursts();
        test_no_transfer();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge hclk);
        $display("Timeout: bus traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ahb_subsystem_asserts.sv ====
`default_nettype none

module ahb_subsystem_asserts (
     input logic               hclk
    ,input logic               hresetn
    ,input ahb_pkg::ahb_resp_t ahb_resp
    ,input ahb_pkg::mem_req_t  mem_req
);
    timeunit 1ns;
    timeprecision 100ps;

    property p_single_direction;
        @(posedge hclk) disable iff (!hresetn)
        !(mem_req.pread && mem_req.pwrite);
    endproperty

    property p_write_has_strobe;
        @(posedge hclk) disable iff (!hresetn)
        mem_req.pwrite |-> (mem_req.pstrb != '0);
    endproperty

    // ERROR response is two cycles, stall then ready
    property p_error_two_cycles;
        @(posedge hclk) disable iff (!hresetn)
        (ahb_resp.hresp && !ahb_resp.hreadyout) |=> (ahb_resp.hresp && ahb_resp.hreadyout);
    endproperty

    property p_ready_after_reset;
        @(posedge hclk)
        $rose(hresetn) |-> ahb_resp.hreadyout;
    endproperty

    a_single_direction: assert property (p_single_direction)
        else $error("pread and pwrite are high in the same cycle");

    a_write_has_strobe: assert property (p_write_has_strobe)
        else $error("RAM write issued with an all-zero byte strobe");

    a_error_two_cycles: assert property (p_error_two_cycles)
        else $error("first ERROR cycle not followed by the ready ERROR cycle");

    a_ready_after_reset: assert property (p_ready_after_reset)
        else $error("hreadyout low in the first cycle after reset");

endmodule

bind ahb_subsystem ahb_subsystem_asserts i_ahb_subsystem_asserts (
     .hclk     (hclk)
    ,.hresetn  (hresetn)
    ,.ahb_resp (ahb_resp)
    ,.mem_req  (mem_req)
);

`default_nettype wire

// ==== verilog/ahb_subsystem.sv ====
`default_nettype none

module ahb_subsystem (
     input  logic               hclk
    ,input  logic               hresetn
    ,input  ahb_pkg::ahb_req_t  ahb_req
    ,input  ahb_pkg::hdata_t    hwdata
    ,output ahb_pkg::ahb_resp_t ahb_resp
);
    import ahb_pkg::*;

    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    ahblite_slave i_ahblite_slave (
         .hclk     (hclk)
        ,.hresetn  (hresetn)
        ,.ahb_req  (ahb_req)
        ,.hwdata   (hwdata)
        ,.ahb_resp (ahb_resp)
        ,.mem_req  (mem_req)
        ,.mem_resp (mem_resp)
    );

    // Single slave, so no decode in between
    periph_ram i_periph_ram (
         .hclk     (hclk)
        ,.hresetn  (hresetn)
        ,.mem_req  (mem_req)
        ,.mem_resp (mem_resp)
    );

endmodule

`default_nettype wire

// ==== verilog/periph_ram.sv ====
`default_nettype none

module periph_ram (
     input  logic               hclk
    ,input  logic               hresetn
    ,input  ahb_pkg::mem_req_t  mem_req
    ,output ahb_pkg::mem_resp_t mem_resp
);
    import ahb_pkg::*;

    hdata_t    mem [RAM_WORDS];
    ram_idx_t  idx;
    wait_cnt_t wait_cnt;
    logic      access;
    logic      pready;

    // Upper address bits are ignored so the space wraps
    assign idx    = mem_req.paddr[RAM_IDX_W+1:2];
    assign access = mem_req.pread || mem_req.pwrite;
    assign pready = access && (wait_cnt == wait_cnt_t'(RAM_WAIT));

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wait_cnt <= '0;
        end else if (pready) begin
            wait_cnt <= '0;                      // Fresh wait for the next request
        end else if (access) begin
            wait_cnt <= wait_cnt + wait_cnt_t'(1);
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && mem_req.pwrite) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mem_req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= mem_req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // Read word only shows on the ready cycle
    always_comb begin
        mem_resp.pready = pready;
        if (pready && mem_req.pread) begin
            mem_resp.prdata = mem[idx];
        end else begin
            mem_resp.prdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ahblite_slave.sv ====
`default_nettype none

module ahblite_slave (
     input  logic               hclk
    ,input  logic               hresetn
    ,input  ahb_pkg::ahb_req_t  ahb_req
    ,input  ahb_pkg::hdata_t    hwdata
    ,output ahb_pkg::ahb_resp_t ahb_resp
    ,output ahb_pkg::mem_req_t  mem_req
    ,input  ahb_pkg::mem_resp_t mem_resp
);
    import ahb_pkg::*;

    dphase_t state;
    dphase_t state_nxt;
    dphase_t start_state;
    logic    trans_active;
    logic    accept;
    logic    size_ok;
    logic    hreadyout;
    logic    hresp;

    haddr_t  dp_addr;
    hsize_t  dp_size;
    logic    dp_write;
    strb_t   dp_strb;

    // Only NONSEQ and SEQ carry a transfer
    always_comb begin
        case (ahb_req.htrans)
            HTRANS_NONSEQ, HTRANS_SEQ: trans_active = 1'b1;
            HTRANS_IDLE, HTRANS_BUSY:  trans_active = 1'b0;
            default:                   trans_active = 1'b0;
        endcase
    end

    assign accept  = ahb_req.hsel && trans_active && hreadyout;
    assign size_ok = (ahb_req.hsize <= HSIZE_WORD);

    always_comb begin
        if (!accept) begin
            start_state = DP_IDLE;
        end else if (size_ok) begin
            start_state = DP_XFER;
        end else begin
            start_state = DP_ERR1;               // Oversized, RAM never sees it
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            DP_IDLE: state_nxt = start_state;
            DP_XFER: begin
                if (mem_resp.pready) begin
                    state_nxt = start_state;     // Next address phase overlaps
                end
            end
            DP_ERR1: state_nxt = DP_ERR2;
            DP_ERR2: state_nxt = start_state;
            default: state_nxt = DP_IDLE;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state <= DP_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Address phase capture
    always_ff @(posedge hclk) begin
        if (accept) begin
            dp_addr  <= ahb_req.haddr;
            dp_write <= ahb_req.hwrite;
            dp_size  <= ahb_req.hsize;
        end
    end

    always_comb begin
        case (dp_size)
            HSIZE_BYTE: dp_strb = strb_t'(1) << dp_addr[1:0];
            HSIZE_HALF: dp_strb = dp_addr[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: dp_strb = '1;
            default:    dp_strb = '0;
        endcase
    end

    always_comb begin
        case (state)
            DP_XFER: hreadyout = mem_resp.pready;
            DP_ERR1: hreadyout = 1'b0;           // First error cycle stalls
            default: hreadyout = 1'b1;
        endcase
    end

    assign hresp = (state == DP_ERR1) || (state == DP_ERR2);

    always_comb begin
        ahb_resp.hrdata    = mem_resp.prdata;
        ahb_resp.hreadyout = hreadyout;
        ahb_resp.hresp     = hresp;
    end

    // Live hwdata is the data-phase write data
    always_comb begin
        mem_req.paddr  = dp_addr;
        mem_req.pwdata = hwdata;
        mem_req.pstrb  = dp_strb;
        mem_req.pwrite = (state == DP_XFER) && dp_write;
        mem_req.pread  = (state == DP_XFER) && !dp_write;
    end

endmodule

`default_nettype wire

// ==== verilog/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int RAM_WORDS  = 256;
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);
    localparam int RAM_WAIT   = 2;                     // Wait states per access
    localparam int WAIT_CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    typedef logic [ADDR_W-1:0]     haddr_t;
    typedef logic [DATA_W-1:0]     hdata_t;
    typedef logic [2:0]            hsize_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [RAM_IDX_W-1:0]  ram_idx_t;
    typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

    localparam logic [1:0] HTRANS_IDLE   = 2'd0;
    localparam logic [1:0] HTRANS_BUSY   = 2'd1;
    localparam logic [1:0] HTRANS_NONSEQ = 2'd2;
    localparam logic [1:0] HTRANS_SEQ    = 2'd3;

    localparam hsize_t HSIZE_BYTE = 3'd0;
    localparam hsize_t HSIZE_HALF = 3'd1;
    localparam hsize_t HSIZE_WORD = 3'd2;              // Largest legal size

    typedef struct packed {
        logic       hsel;
        logic [1:0] htrans;
        logic       hwrite;
        hsize_t     hsize;
        haddr_t     haddr;
    } ahb_req_t;

    typedef struct packed {
        hdata_t hrdata;
        logic   hreadyout;
        logic   hresp;
    } ahb_resp_t;

    typedef struct packed {
        haddr_t paddr;
        hdata_t pwdata;
        strb_t  pstrb;
        logic   pwrite;
        logic   pread;
    } mem_req_t;

    typedef struct packed {
        hdata_t prdata;
        logic   pready;
    } mem_resp_t;

    typedef enum logic [1:0] {
        DP_IDLE = 2'd0,
        DP_XFER = 2'd1,
        DP_ERR1 = 2'd2,
        DP_ERR2 = 2'd3
    } dphase_t;

endpackage

`default_nettype wire
